// ==== Bender.yml ====
package:
  name: cdi_glue

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - design/cdi_bus_pkg.sv
      - design/cdi_port_pkg.sv
      - design/cdi_bus_if.sv
      - design/attex_decode.sv
      - design/nvram_window.sv
      - design/slave_port_block.sv
      - design/bus_return_mux.sv
      - design/cdi_glue_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/cdi_glue_tb.sv

// ==== design/attex_decode.sv ====
`timescale 1ns/1ps
`include "cdi_bus_macros.svh"

module attex_decode (
    input  logic [`CDI_ADDR_W:1] addr,
    input  logic                 as,
    input  logic                 uds,
    input  logic                 lds,
    input  logic                 write_strobe,
    input  logic [15:0]          wdata,
    cdi_bus_if.decoder           bus,
    output logic                 bus_err
);

    logic [23:0] addr_byte;
    logic        video_hit;
    logic        dvc_hit;
    logic        err_area1;
    logic        err_area2;

    cdi_bus_pkg::region_sel_t sel_n;
    cdi_bus_pkg::cpu_cycle_t  cycle_n;

    assign addr_byte = {addr, 1'b0};

    // Video window excludes the upper half of the map
    assign video_hit = ((addr_byte <= `CDI_VIDEO_LIMIT) || (addr_byte >= `CDI_VIDEO_HIGH))
                       && !addr[23];
    assign dvc_hit = (addr_byte[23:20] == 4'hd) || (addr_byte[23:19] == 5'b11101);

    assign err_area1 = (addr_byte >= `CDI_RAM_ERR_LO) && (addr_byte < `CDI_RAM_ERR_HI);
    assign err_area2 = addr_byte >= `CDI_RAM_ERR_TOP;

    // Strobeless cycles never fault
    assign bus_err = (err_area1 || err_area2) && as && (uds || lds);

    always_comb begin
        sel_n.video   = video_hit && as;
        sel_n.dvc_ram = dvc_hit && as;
        sel_n.cdic    = (addr_byte[23:16] == `CDI_CDIC_PAGE) && as;
        sel_n.slave   = (addr_byte[23:16] == `CDI_SLAVE_PAGE) && as;
        sel_n.nvram   = (addr_byte[23:16] == `CDI_NVRAM_PAGE) && as;
    end

    always_comb begin
        cycle_n.addr         = addr;
        cycle_n.wdata        = wdata;
        cycle_n.uds          = uds;
        cycle_n.lds          = lds;
        cycle_n.write_strobe = write_strobe;
    end

    assign bus.sel   = sel_n;
    assign bus.cycle = cycle_n;

endmodule

// ==== design/bus_return_mux.sv ====
`timescale 1ns/1ps

module bus_return_mux (
    cdi_bus_if.device   bus,
    input  logic        iack_cdic,
    input  logic [7:0]  nvram_rdata,
    input  logic [7:0]  slave_rdata,
    input  logic        nvram_ack,
    input  logic        slave_ack,
    input  logic [15:0] cdic_data,
    input  logic [15:0] video_data,
    input  logic        cdic_ack,
    input  logic        video_ack,
    output logic [15:0] data_in,
    output logic        bus_ack
);

    always_comb begin
        // Unmapped space acks at once and reads zero
        bus_ack = 1'b1;
        data_in = 16'h0000;

        if (bus.sel.slave) begin
            data_in = {slave_rdata, slave_rdata};
            bus_ack = slave_ack;
        end else if (bus.sel.cdic) begin
            data_in = cdic_data;
            bus_ack = cdic_ack;
        end else if (bus.sel.nvram) begin
            data_in = {nvram_rdata, nvram_rdata};  // Byte on both lanes
            bus_ack = nvram_ack;
        end else if (bus.sel.video || bus.sel.dvc_ram) begin
            data_in = video_data;
            bus_ack = video_ack;
        end

        // CDIC supplies its own vector during interrupt acknowledge
        if (iack_cdic) begin
            data_in = cdic_data;
            bus_ack = 1'b1;
        end
    end

endmodule

// ==== design/cdi_bus_if.sv ====
`timescale 1ns/1ps

// Decoded CPU cycle shared by the decoder and the devices behind it
interface cdi_bus_if;

    cdi_bus_pkg::cpu_cycle_t  cycle;
    cdi_bus_pkg::region_sel_t sel;

    modport decoder (
        output cycle,
        output sel
    );

    modport device (
        input cycle,
        input sel
    );

endinterface

// ==== design/cdi_bus_pkg.sv ====
`include "cdi_bus_macros.svh"

package cdi_bus_pkg;

    // One bit per decoded region, already qualified by as
    typedef struct packed {
        logic video;
        logic dvc_ram;
        logic cdic;
        logic slave;
        logic nvram;
    } region_sel_t;

    // CPU cycle as presented by the 68000 style bus
    typedef struct packed {
        logic [`CDI_ADDR_W:1] addr;  // Word address
        logic [15:0]          wdata;
        logic                 uds;   // Upper lane, bits 15:8
        logic                 lds;   // Lower lane, bits 7:0
        logic                 write_strobe;
    } cpu_cycle_t;

endpackage

// ==== design/cdi_glue_top.sv ====
`timescale 1ns/1ps
`include "cdi_bus_macros.svh"

module cdi_glue_top (
    input  logic                 clk30,
    input  logic                 reset,

    // CPU bus
    input  logic [`CDI_ADDR_W:1] addr,
    input  logic                 as,
    input  logic                 uds,
    input  logic                 lds,
    input  logic                 write_strobe,
    input  logic [15:0]          wdata,
    output logic                 bus_ack,
    output logic [15:0]          data_in,
    output logic                 bus_err,
    input  logic                 iack_cdic,

    // External video chip and CDIC
    output logic                 video_cs,
    output logic                 cdic_cs,
    input  logic [15:0]          video_data,
    input  logic                 video_ack,
    input  logic [15:0]          cdic_data,
    input  logic                 cdic_ack,

    input  logic                 tvmode_pal,

    // Slave controller pins
    output logic                 slave_irq,
    output logic                 slave_rts,
    output logic                 irq2_in,
    output logic                 sys_reset_req,
    output logic                 disdat,
    output logic                 disclk,

    output logic                 nvram_cpu_changed
);

    cdi_bus_if bus ();

    logic [7:0] nvram_rdata;
    logic [7:0] slave_rdata;
    logic       nvram_ack;
    logic       slave_ack;

    attex_decode u_decode (
        .addr         (addr),
        .as           (as),
        .uds          (uds),
        .lds          (lds),
        .write_strobe (write_strobe),
        .wdata        (wdata),
        .bus          (bus.decoder),
        .bus_err      (bus_err)
    );

    nvram_window u_nvram (
        .clk30             (clk30),
        .reset             (reset),
        .bus               (bus.device),
        .nvram_rdata       (nvram_rdata),
        .nvram_ack         (nvram_ack),
        .nvram_cpu_changed (nvram_cpu_changed)
    );

    slave_port_block u_slave (
        .clk30         (clk30),
        .reset         (reset),
        .bus           (bus.device),
        .tvmode_pal    (tvmode_pal),
        .slave_rdata   (slave_rdata),
        .slave_ack     (slave_ack),
        .slave_irq     (slave_irq),
        .slave_rts     (slave_rts),
        .irq2_in       (irq2_in),
        .sys_reset_req (sys_reset_req),
        .disdat        (disdat),
        .disclk        (disclk)
    );

    bus_return_mux u_mux (
        .bus         (bus.device),
        .iack_cdic   (iack_cdic),
        .nvram_rdata (nvram_rdata),
        .slave_rdata (slave_rdata),
        .nvram_ack   (nvram_ack),
        .slave_ack   (slave_ack),
        .cdic_data   (cdic_data),
        .video_data  (video_data),
        .cdic_ack    (cdic_ack),
        .video_ack   (video_ack),
        .data_in     (data_in),
        .bus_ack     (bus_ack)
    );

    // Video chip also serves the DVC RAM pages
    assign video_cs = bus.sel.video || bus.sel.dvc_ram;
    assign cdic_cs  = bus.sel.cdic;

endmodule

// ==== design/cdi_port_pkg.sv ====
package cdi_port_pkg;

    // Port C as seen by the slave controller
    typedef struct packed {
        logic [2:0] spare_hi;
        logic       disclk;
        logic       disdat;
        logic       resetsys;
        logic [1:0] spare_lo;
    } portc_ctl_t;

    typedef union packed {
        logic [7:0] raw;  // CPU readback
        portc_ctl_t ctl;
    } portc_word_t;

    // Port B carries the audio DAC lines and the slave handshake pins
    typedef struct packed {
        logic       spare;
        logic       dtack_n;
        logic       irq2_n;
        logic       rts_n;
        logic [3:0] dac;  // csdac2n, csdac1n, clkdac, datadac
    } portb_ctl_t;

    typedef union packed {
        logic [7:0] raw;
        portb_ctl_t ctl;
    } portb_word_t;

    // Register selected by word address bits 3:1
    typedef enum logic [2:0] {
        portb_data   = 3'd0,
        portb_ddr    = 3'd1,
        portc_data   = 3'd2,
        portc_ddr    = 3'd3,
        porta_mirror = 3'd4
    } slave_reg_e;

endpackage

// ==== design/nvram_window.sv ====
`timescale 1ns/1ps
`include "cdi_bus_macros.svh"

module nvram_window (
    input  logic        clk30,
    input  logic        reset,
    cdi_bus_if.device   bus,
    output logic [7:0]  nvram_rdata,
    output logic        nvram_ack,
    output logic        nvram_cpu_changed
);

    logic [7:0] mem [0:(2**`CDI_NVRAM_AW)-1];

    logic                    sel_q;
    logic                    sel_rise;
    logic                    cpu_write;
    logic [`CDI_NVRAM_AW:1]  waddr;

    assign waddr    = bus.cycle.addr[`CDI_NVRAM_AW:1];
    assign sel_rise = bus.sel.nvram && !sel_q;

    // Byte device lives on the upper lane only
    assign cpu_write = sel_rise && bus.cycle.write_strobe && bus.cycle.uds;

    always_ff @(posedge clk30) begin
        if (reset) begin
            sel_q <= 1'b0;
        end else begin
            sel_q <= bus.sel.nvram;
        end
    end

    always_ff @(posedge clk30) begin
        if (cpu_write) begin
            mem[waddr] <= bus.cycle.wdata[15:8];
        end
        nvram_rdata <= mem[waddr];  // Valid from the second cycle on
    end

    // Sticky until reset, polled by the backup agent
    always_ff @(posedge clk30) begin
        if (reset) begin
            nvram_cpu_changed <= 1'b0;
        end else if (cpu_write) begin
            nvram_cpu_changed <= 1'b1;
        end
    end

    assign nvram_ack = bus.sel.nvram && sel_q;  // Held until the CPU drops as

endmodule

// ==== design/slave_port_block.sv ====
`timescale 1ns/1ps

module slave_port_block (
    input  logic       clk30,
    input  logic       reset,
    cdi_bus_if.device  bus,
    input  logic       tvmode_pal,
    output logic [7:0] slave_rdata,
    output logic       slave_ack,
    output logic       slave_irq,
    output logic       slave_rts,
    output logic       irq2_in,
    output logic       sys_reset_req,
    output logic       disdat,
    output logic       disclk
);

    // Pin levels while the DDR bit is clear
    localparam logic [7:0] portb_pin_dflt = 8'hfc;
    localparam logic [7:0] portc_pin_dflt = 8'hf8;

    cdi_port_pkg::portb_word_t portb_reg;
    cdi_port_pkg::portc_word_t portc_reg;
    cdi_port_pkg::portb_word_t portb_pins;
    cdi_port_pkg::portc_word_t portc_pins;
    cdi_port_pkg::slave_reg_e  reg_sel;

    logic [7:0] portb_dir;
    logic [7:0] portc_dir;
    logic [7:0] porta_last;
    logic       sel_q;
    logic       reg_write;

    assign reg_sel   = cdi_port_pkg::slave_reg_e'(bus.cycle.addr[3:1]);
    assign slave_irq = bus.sel.slave && !sel_q;  // One pulse per access
    assign slave_ack = bus.sel.slave && sel_q;
    assign reg_write = slave_irq && bus.cycle.write_strobe && bus.cycle.lds;

    always_ff @(posedge clk30) begin
        if (reset) begin
            sel_q      <= 1'b0;
            portb_reg  <= '0;
            portc_reg  <= '0;
            portb_dir  <= 8'h00;
            portc_dir  <= 8'h00;
            porta_last <= 8'h00;
        end else begin
            sel_q <= bus.sel.slave;
            if (reg_write) begin
                porta_last <= bus.cycle.wdata[7:0];
                case (reg_sel)
                    cdi_port_pkg::portb_data: portb_reg.raw <= bus.cycle.wdata[7:0];
                    cdi_port_pkg::portb_ddr:  portb_dir     <= bus.cycle.wdata[7:0];
                    cdi_port_pkg::portc_data: portc_reg.raw <= bus.cycle.wdata[7:0];
                    cdi_port_pkg::portc_ddr:  portc_dir     <= bus.cycle.wdata[7:0];
                    default: ;
                endcase
            end
        end
    end

    // Output where DDR is set, default level elsewhere
    always_comb begin
        portb_pins.raw = (portb_reg.raw & portb_dir) | (portb_pin_dflt & ~portb_dir);
        portc_pins.raw = (portc_reg.raw & portc_dir) | (portc_pin_dflt & ~portc_dir);
    end

    assign slave_rts     = portb_pins.ctl.rts_n;
    assign irq2_in       = !portb_pins.ctl.irq2_n;  // CPU side is active high
    assign sys_reset_req = portc_pins.ctl.resetsys;
    assign disdat        = portc_pins.ctl.disdat;
    assign disclk        = portc_pins.ctl.disclk;

    always_comb begin
        case (reg_sel)
            cdi_port_pkg::portb_data: slave_rdata = portb_reg.raw;
            cdi_port_pkg::portb_ddr:  slave_rdata = portb_dir;
            // Bit 7 reports NTSC, low bits echo the address
            cdi_port_pkg::portc_data:
                slave_rdata = {!tvmode_pal, portc_pins.raw[6:2], bus.cycle.addr[2:1]};
            cdi_port_pkg::portc_ddr:  slave_rdata = portc_dir;
            cdi_port_pkg::porta_mirror: slave_rdata = porta_last;
            default: slave_rdata = 8'h00;
        endcase
    end

endmodule

// ==== include/cdi_bus_macros.svh ====
`ifndef CDI_BUS_MACROS_SVH
`define CDI_BUS_MACROS_SVH

// CPU word address, bits 23:1
`define CDI_ADDR_W 23

// Unpopulated RAM areas that answer with a bus error
`define CDI_RAM_ERR_LO 24'h600000
`define CDI_RAM_ERR_HI 24'hd00000
`define CDI_RAM_ERR_TOP 24'hf00000

// 64 KiB pages, compared against byte address bits 23:16
`define CDI_CDIC_PAGE 8'h30
`define CDI_SLAVE_PAGE 8'h31
`define CDI_NVRAM_PAGE 8'h32

// Video chip owns everything up to the limit and from the high mark up
`define CDI_VIDEO_LIMIT 24'h27ffff
`define CDI_VIDEO_HIGH 24'h400000

// 8192 bytes of battery backed RAM
`define CDI_NVRAM_AW 13

`endif

// ==== sources.f ====
+incdir+include
design/cdi_bus_pkg.sv
design/cdi_port_pkg.sv
design/cdi_bus_if.sv
design/attex_decode.sv
design/nvram_window.sv
design/slave_port_block.sv
design/bus_return_mux.sv
design/cdi_glue_top.sv
verif/cdi_glue_tb.sv

// ==== verif/cdi_glue_tb.sv ====
`timescale 1ns/1ps
`include "cdi_bus_macros.svh"

module cdi_glue_tb;

    localparam int num_entries   = 28;
    localparam int wait_limit    = 4;
    localparam int timeout_limit = num_entries * 8 + 64 * 2 * 8 + 100;

    localparam logic [15:0] video_word = 16'h5a1d;
    localparam logic [15:0] cdic_word  = 16'hc3d1;
    localparam logic [4:0]  pins_dflt  = 5'b10011;  // rts, irq2_in, sys_reset_req, disdat, disclk

    typedef struct packed {
        logic [23:0] addr;      // Byte address
        logic [1:0]  strobes;   // uds, lds
        logic        wr;
        logic [15:0] wdata;
        logic        iack;
        logic        pal;
        logic        chk_data;
        logic [15:0] exp_data;
        logic        exp_err;
        logic [1:0]  exp_cs;    // video_cs, cdic_cs
        logic [1:0]  exp_wait;
        logic        exp_irq;
        logic [4:0]  exp_pins;
    } stim_entry_t;

    logic                 clk30;
    logic                 reset;
    logic [`CDI_ADDR_W:1] addr;
    logic                 as;
    logic                 uds;
    logic                 lds;
    logic                 write_strobe;
    logic [15:0]          wdata;
    logic                 iack_cdic;
    logic                 tvmode_pal;
    logic                 bus_ack;
    logic [15:0]          data_in;
    logic                 bus_err;
    logic                 video_cs;
    logic                 cdic_cs;
    logic [15:0]          video_data;
    logic                 video_ack;
    logic [15:0]          cdic_data;
    logic                 cdic_ack;
    logic                 slave_irq;
    logic                 slave_rts;
    logic                 irq2_in;
    logic                 sys_reset_req;
    logic                 disdat;
    logic                 disclk;
    logic                 nvram_cpu_changed;

    stim_entry_t stim [num_entries];
    logic [7:0]  shadow [0:(2**`CDI_NVRAM_AW)-1];
    logic [12:0] rnd_addr [0:63];
    int          n_loaded;
    int          errors;
    int          checks;
    int          cycles;

    cdi_glue_top uut (.*);

    // External responders answer in the same cycle
    assign video_data = video_word;
    assign video_ack  = video_cs;
    assign cdic_data  = cdic_word;  // Also the interrupt vector
    assign cdic_ack   = cdic_cs;

    initial begin
        clk30 = 1'b0;
        forever #2 clk30 = ~clk30;
    end

    always @(posedge clk30) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_limit) begin
            $display("Timeout after %0d cycles, the tests did not reach their end", cycles);
            $display("Checks: %0d, errors: %0d", checks, errors);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic add_entry(input logic [23:0] a, input logic [1:0] strb, input logic w,
                             input logic [15:0] wd, input logic ia, input logic pal,
                             input logic chk, input logic [15:0] exp_d, input logic exp_e,
                             input logic [1:0] exp_c, input logic [1:0] exp_w,
                             input logic exp_i, input logic [4:0] exp_p);
        stim[n_loaded] = {a, strb, w, wd, ia, pal, chk, exp_d, exp_e, exp_c, exp_w, exp_i, exp_p};
        n_loaded++;
    endtask

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] expected);
        checks++;
        assert (got === expected) else begin
            errors++;
            $display("[FAIL] %s got %h expected %h", name, got, expected);
        end
    endtask

    // Holds the cycle until bus_ack, sampling on falling edges
    task automatic drive_cycle(input logic [23:0] byte_addr, input logic u, input logic l,
                               input logic w, input logic [15:0] wd, input logic ia,
                               output int waits, output int irqs);
        logic acked;
        @(posedge clk30);
        #1;
        addr         = byte_addr[23:1];
        as           = 1'b1;
        uds          = u;
        lds          = l;
        write_strobe = w;
        wdata        = wd;
        iack_cdic    = ia;
        waits = 0;
        irqs  = 0;
        acked = 1'b0;
        while (!acked && waits < wait_limit) begin
            @(negedge clk30);
            if (slave_irq) irqs++;
            if (bus_ack) acked = 1'b1;
            else waits++;
        end
        checks++;
        assert (acked) else begin
            errors++;
            $display("Cycle at %h got no bus acknowledge within %0d cycles", byte_addr, wait_limit);
        end
    endtask

    task automatic release_bus();
        @(posedge clk30);
        #1;
        as           = 1'b0;
        uds          = 1'b0;
        lds          = 1'b0;
        write_strobe = 1'b0;
        iack_cdic    = 1'b0;
    endtask

    task automatic load_table();
        // addr, uds/lds, wr, wdata, iack, pal, chk, data, err, cs, wait, irq, pins
        add_entry('h000100, 'b11, 0, 'h0000, 0, 1, 1, video_word, 0, 'b10, 0, 0, pins_dflt);
        add_entry('h27fffe, 'b11, 0, 'h0000, 0, 1, 1, video_word, 0, 'b10, 0, 0, pins_dflt);
        add_entry('h280000, 'b11, 0, 'h0000, 0, 1, 1, 'h0000, 0, 'b00, 0, 0, pins_dflt);
        add_entry('h500000, 'b11, 0, 'h0000, 0, 1, 1, video_word, 0, 'b10, 0, 0, pins_dflt);
        add_entry('hd00000, 'b11, 0, 'h0000, 0, 1, 1, video_word, 0, 'b10, 0, 0, pins_dflt);
        add_entry('he80000, 'b10, 0, 'h0000, 0, 1, 1, video_word, 0, 'b10, 0, 0, pins_dflt);
        add_entry('he00000, 'b11, 0, 'h0000, 0, 1, 1, 'h0000, 0, 'b00, 0, 0, pins_dflt);
        add_entry('h300000, 'b11, 0, 'h0000, 0, 1, 1, cdic_word, 0, 'b01, 0, 0, pins_dflt);
        add_entry('h320000, 'b11, 0, 'h0000, 0, 1, 0, 'h0000, 0, 'b00, 1, 0, pins_dflt);
        add_entry('h800000, 'b10, 0, 'h0000, 0, 1, 1, 'h0000, 1, 'b00, 0, 0, pins_dflt);
        add_entry('h800000, 'b00, 0, 'h0000, 0, 1, 1, 'h0000, 0, 'b00, 0, 0, pins_dflt);
        add_entry('hf80000, 'b01, 0, 'h0000, 0, 1, 1, 'h0000, 1, 'b00, 0, 0, pins_dflt);
        add_entry('h000200, 'b11, 0, 'h0000, 1, 1, 1, cdic_word, 0, 'b10, 0, 0, pins_dflt);
        add_entry('h310004, 'b11, 0, 'h0000, 1, 1, 1, cdic_word, 0, 'b00, 0, 1, pins_dflt);
        // Port C reads carry NTSC in bit 7 and address bits 2:1 below
        add_entry('h310004, 'b11, 0, 'h0000, 0, 1, 1, 'h7a7a, 0, 'b00, 1, 1, pins_dflt);
        add_entry('h310004, 'b11, 0, 'h0000, 0, 0, 1, 'hfafa, 0, 'b00, 1, 1, pins_dflt);
        add_entry('h310006, 'b01, 1, 'h001c, 0, 1, 0, 'h0000, 0, 'b00, 1, 1, 'b10000);
        add_entry('h310004, 'b01, 1, 'h0004, 0, 1, 0, 'h0000, 0, 'b00, 1, 1, 'b10100);
        add_entry('h310004, 'b11, 0, 'h0000, 0, 1, 1, 'h6666, 0, 'b00, 1, 1, 'b10100);
        add_entry('h310006, 'b01, 1, 'h0000, 0, 1, 0, 'h0000, 0, 'b00, 1, 1, pins_dflt);
        add_entry('h310002, 'b01, 1, 'h0020, 0, 1, 0, 'h0000, 0, 'b00, 1, 1, 'b11011);
        add_entry('h310000, 'b01, 1, 'h0020, 0, 1, 0, 'h0000, 0, 'b00, 1, 1, pins_dflt);
        add_entry('h310002, 'b01, 1, 'h0030, 0, 1, 0, 'h0000, 0, 'b00, 1, 1, 'b00011);
        add_entry('h310008, 'b11, 0, 'h0000, 0, 1, 1, 'h3030, 0, 'b00, 1, 1, 'b00011);
        add_entry('h310000, 'b11, 0, 'h0000, 0, 1, 1, 'h2020, 0, 'b00, 1, 1, 'b00011);
        add_entry('h310002, 'b01, 1, 'h0000, 0, 1, 0, 'h0000, 0, 'b00, 1, 1, pins_dflt);
        add_entry('h310006, 'b10, 1, 'h00ff, 0, 1, 0, 'h0000, 0, 'b00, 1, 1, pins_dflt);
        add_entry('h310006, 'b11, 0, 'h0000, 0, 1, 1, 'h0000, 0, 'b00, 1, 1, pins_dflt);
    endtask

    initial begin
        stim_entry_t e;
        int          waits;
        int          irqs;
        logic [7:0]  rnd_byte;
        logic [7:0]  junk;
        logic [23:0] nv_addr;

        void'($urandom(32'h27b3));
        n_loaded = 0;
        errors   = 0;
        checks   = 0;
        cycles   = 0;
        reset        = 1'b1;
        addr         = '0;
        as           = 1'b0;
        uds          = 1'b0;
        lds          = 1'b0;
        write_strobe = 1'b0;
        wdata        = 16'h0000;
        iack_cdic    = 1'b0;
        tvmode_pal   = 1'b1;
        load_table();

        repeat (8) @(posedge clk30);
        #1;
        reset = 1'b0;
        check_value("slave_irq", slave_irq, 0);
        check_value("nvram_cpu_changed", nvram_cpu_changed, 0);

        for (int i = 0; i < num_entries; i++) begin
            e = stim[i];
            tvmode_pal = e.pal;
            drive_cycle(e.addr, e.strobes[1], e.strobes[0], e.wr, e.wdata, e.iack,
                        waits, irqs);
            if (e.chk_data) check_value($sformatf("data_in (entry %0d)", i), data_in, e.exp_data);
            check_value($sformatf("bus_err (entry %0d)", i), bus_err, e.exp_err);
            check_value($sformatf("video_cs/cdic_cs (entry %0d)", i), {video_cs, cdic_cs},
                        e.exp_cs);
            check_value($sformatf("ack wait (entry %0d)", i), waits, e.exp_wait);
            check_value($sformatf("slave_irq pulses (entry %0d)", i), irqs, e.exp_irq);
            check_value($sformatf("slave pins (entry %0d)", i),
                        {slave_rts, irq2_in, sys_reset_req, disdat, disclk}, e.exp_pins);
            release_bus();
        end

        // Random NVRAM traffic, checked against a shadow copy
        for (int i = 0; i < 64; i++) begin
            rnd_addr[i] = $urandom % 8192;
            rnd_byte = $urandom;
            junk     = $urandom;
            shadow[rnd_addr[i]] = rnd_byte;
            nv_addr = {`CDI_NVRAM_PAGE, 2'b00, rnd_addr[i], 1'b0};
            drive_cycle(nv_addr, 1'b1, i[0], 1'b1, {rnd_byte, junk}, 1'b0, waits, irqs);
            check_value($sformatf("nvram write ack wait (%0d)", i), waits, 1);
            check_value("nvram_cpu_changed", nvram_cpu_changed, 1);
            release_bus();
        end
        for (int i = 0; i < 64; i++) begin
            nv_addr = {`CDI_NVRAM_PAGE, 2'b00, rnd_addr[i], 1'b0};
            drive_cycle(nv_addr, 1'b1, 1'b1, 1'b0, 16'h0000, 1'b0, waits, irqs);
            check_value($sformatf("data_in (nvram %h)", nv_addr), data_in,
                        {shadow[rnd_addr[i]], shadow[rnd_addr[i]]});
            check_value($sformatf("nvram read ack wait (%0d)", i), waits, 1);
            release_bus();
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
